//--- logic/lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;

    // ####################
    // opcodes and alu ops
    // ####################

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_ldi  = 4'b1000,   // 1010 stays unnamed and decodes as unknown
        op_not  = 4'b1001,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    // ####################
    // instruction word
    // ####################

    // one word seen as alu/shift format or as memory/control flow format
    typedef union packed {
        struct packed {
            lc3b_opcode  opcode;
            logic [2:0]  dr;
            logic [2:0]  sr1;
            logic        imm_flag;   // bit 5
            logic        d_flag;     // bit 4 selects shift direction
            logic [3:0]  low;
        } alu;
        struct packed {
            lc3b_opcode  opcode;
            logic [2:0]  dr;         // nzp on br and jsr flag in bit 11
            logic [2:0]  base;
            logic [5:0]  offset6;
        } mem;
    } lc3b_inst;

    typedef struct packed {
        lc3b_opcode  opcode;
        logic        load_pc;
        logic        load_ir;
        logic        load_regfile;
        logic        load_mar;
        logic        load_mdr;
        logic        load_cc;
        logic        regfile_filter_enable;
        logic        stb_filter_enable;
        logic [1:0]  pcmux_sel;
        logic        brmux_sel;
        logic        storemux_sel;
        logic        destmux_sel;
        logic [1:0]  alumux_sel;
        logic [1:0]  regfilemux_sel;
        logic [1:0]  marmux_sel;
        logic        mdrmux_sel;
        logic        offsetaddermux_sel;
        logic        offset6mux_sel;
        lc3b_aluop   aluop;
        logic        mem_read;
        logic        mem_write;
        logic        indirect_enable;
        logic [1:0]  mem_byte_enable;
        logic        is_nop;
    } lc3b_control_word;

endpackage : lc3b_types

//--- logic/apb_types.sv
package apb_types;

    // fetch port widths
    parameter int APB_ADDR_W = 16;
    parameter int APB_DATA_W = 16;

    typedef logic [APB_ADDR_W-1:0] apb_addr;   // byte address

endpackage : apb_types

//--- logic/control_rom.sv
`timescale 1ns/1ps

module control_rom
    import lc3b_types::*;
(
    input  lc3b_opcode        opcode,
    input  logic              imm_enable,
    input  logic              jsr_enable,
    input  logic              d_enable,
    input  logic              stb_high_enable,
    input  logic              is_nop,
    output lc3b_control_word  ctrl
);

    always_comb
    begin
        // defaults, all strobes off and word access
        ctrl                 = '0;
        ctrl.opcode          = opcode;
        ctrl.aluop           = alu_add;
        ctrl.mem_byte_enable = 2'b11;
        ctrl.is_nop          = is_nop;

        case (opcode)
            // ####################
            // alu and shift
            // ####################
            op_add, op_and:
            begin
                ctrl.aluop        = (opcode == op_and) ? alu_and : alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                if (imm_enable)
                    ctrl.alumux_sel = 2'b10;   // sext imm5 operand
            end

            op_not:
            begin
                ctrl.aluop        = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end

            op_shf:
            begin
                ctrl.alumux_sel   = 2'b11;   // imm4 shift amount
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                if (!d_enable)
                    ctrl.aluop = alu_sll;
                else if (!imm_enable)
                    ctrl.aluop = alu_srl;   // zero fill
                else
                    ctrl.aluop = alu_sra;   // sign fill
            end

            // ####################
            // loads and stores
            // ####################
            op_ldr, op_ldb, op_ldi:
            begin
                // base + offset into mar
                ctrl.alumux_sel   = 2'b01;
                ctrl.load_mar     = 1'b1;

                ctrl.mdrmux_sel   = 1'b1;   // mdr from memory
                ctrl.load_mdr     = 1'b1;
                ctrl.mem_read     = 1'b1;

                ctrl.regfilemux_sel = 2'b01;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;

                if (opcode == op_ldb)
                begin
                    ctrl.offset6mux_sel        = 1'b1;   // byte offset
                    ctrl.regfile_filter_enable = 1'b1;   // zext low byte
                end
                if (opcode == op_ldi)
                    ctrl.indirect_enable = 1'b1;
            end

            op_str:
            begin
                ctrl.alumux_sel   = 2'b01;
                ctrl.load_mar     = 1'b1;
                ctrl.storemux_sel = 1'b1;   // sr into mdr
                ctrl.load_mdr     = 1'b1;
                ctrl.mem_write    = 1'b1;
            end

            op_stb:
            begin
                ctrl.alumux_sel        = 2'b01;
                ctrl.load_mar          = 1'b1;
                ctrl.offset6mux_sel    = 1'b1;
                ctrl.storemux_sel      = 1'b1;
                ctrl.stb_filter_enable = 1'b1;
                ctrl.load_mdr          = 1'b1;
                ctrl.mem_write         = 1'b1;
                ctrl.mem_byte_enable   = stb_high_enable ? 2'b10 : 2'b01;
            end

            // pointer fetch first, the store itself follows the indirection
            op_sti:
            begin
                ctrl.indirect_enable = 1'b1;
                ctrl.alumux_sel      = 2'b01;
                ctrl.load_mar        = 1'b1;
                ctrl.mdrmux_sel      = 1'b1;
                ctrl.load_mdr        = 1'b1;
                ctrl.storemux_sel    = 1'b1;
            end

            op_lea:
            begin
                ctrl.regfilemux_sel = 2'b10;   // pc + sext(off9) << 1
                ctrl.load_regfile   = 1'b1;
            end

            // ####################
            // control flow
            // ####################
            op_br:
            begin
                if (!is_nop)
                begin
                    ctrl.brmux_sel = 1'b1;
                    ctrl.load_pc   = 1'b1;
                end
            end

            op_jmp:
            begin
                ctrl.pcmux_sel = 2'b10;   // base register
                ctrl.load_pc   = 1'b1;
            end

            op_jsr:
            begin
                // link into r7
                ctrl.destmux_sel    = 1'b1;
                ctrl.regfilemux_sel = 2'b11;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_pc        = 1'b1;
                if (jsr_enable)
                begin
                    ctrl.offsetaddermux_sel = 1'b1;   // pc relative off11
                    ctrl.pcmux_sel          = 2'b01;
                end
                else
                    ctrl.pcmux_sel = 2'b10;   // jsrr
            end

            op_trap:
            begin
                ctrl.destmux_sel    = 1'b1;
                ctrl.regfilemux_sel = 2'b11;
                ctrl.load_regfile   = 1'b1;

                // vector table lookup then jump through mdr
                ctrl.marmux_sel     = 2'b11;
                ctrl.load_mar       = 1'b1;
                ctrl.mdrmux_sel     = 1'b1;
                ctrl.load_mdr       = 1'b1;
                ctrl.mem_read       = 1'b1;
                ctrl.pcmux_sel      = 2'b11;
                ctrl.load_pc        = 1'b1;
            end

            default:
                ctrl = '0;   // unknown opcode
        endcase
    end

endmodule : control_rom

//--- logic/ifetch_apb.sv
`timescale 1ns/1ps

module ifetch_apb
    import lc3b_types::*;
    import apb_types::*;
#(
    parameter apb_addr RESET_PC = 16'h0000
)
(
    input  logic      clk,
    input  logic      arst_n,
    output apb_addr   paddr,
    output logic      psel,
    output logic      penable,
    input  lc3b_word  prdata,
    input  logic      pready,
    input  logic      pslverr,
    input  logic      full,
    output logic      push_valid,
    output lc3b_word  push_word
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SETUP  = 2'd1;
    localparam logic [1:0] ST_ACCESS = 2'd2;

    logic [1:0] state;
    apb_addr    pc;
    logic       pwrite;
    logic       rd_done;

    assign pwrite  = 1'b0;   // fetch port only reads
    assign rd_done = (state == ST_ACCESS) && pready && !pwrite;

    // ####################
    // transfer FSM
    // ####################

    // idle waits for room, the landed word is already counted in full
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= ST_IDLE;
            pc    <= RESET_PC;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (!full)
                        state <= ST_SETUP;
                ST_SETUP:
                    state <= ST_ACCESS;
                ST_ACCESS:
                    if (rd_done)
                    begin
                        state <= ST_IDLE;
                        pc    <= pc + apb_addr'(2);   // next even address
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    assign paddr   = pc;
    assign psel    = (state != ST_IDLE);
    assign penable = (state == ST_ACCESS);

    // word lands in the queue on the capture edge
    assign push_valid = rd_done;
    assign push_word  = pslverr ? lc3b_word'({APB_DATA_W{1'b0}}) : prdata;   // zero is a nop br

endmodule : ifetch_apb

//--- logic/inst_queue.sv
`timescale 1ns/1ps

module inst_queue
    import lc3b_types::*;
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      push_valid,
    input  lc3b_word  push_word,
    output logic      full,
    input  logic      pop,
    output lc3b_word  q_word,
    output logic      q_empty
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    lc3b_word         mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == (PTR_W+1)'(QUEUE_DEPTH));
    assign q_empty = (count == '0);
    assign q_word  = mem[rd_ptr];   // show-ahead head

    assign do_pop  = pop && !q_empty;
    assign do_push = push_valid && (!full || do_pop);   // full only takes a word alongside a pop

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_word;
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : inst_queue

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import lc3b_types::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  lc3b_word          q_word,
    input  logic              q_empty,
    output logic              pop,
    output lc3b_control_word  ctrl,
    output lc3b_word          ir,
    output logic              ctrl_valid,
    input  logic              ctrl_ready
);

    lc3b_inst          inst;
    lc3b_control_word  rom_ctrl;
    logic              imm_enable;
    logic              d_enable;
    logic              jsr_enable;
    logic              stb_high_enable;
    logic              is_nop;
    logic              out_free;

    // ####################
    // decode flags
    // ####################
    assign inst            = q_word;
    assign imm_enable      = inst.alu.imm_flag;
    assign d_enable        = inst.alu.d_flag;
    assign jsr_enable      = inst.mem.dr[2];      // bit 11
    assign stb_high_enable = inst.mem.offset6[0];
    assign is_nop          = (inst.mem.opcode == op_br) && (inst.mem.dr == 3'b000);   // no nzp

    control_rom u_control_rom
    (
        .opcode          (inst.alu.opcode),
        .imm_enable      (imm_enable),
        .jsr_enable      (jsr_enable),
        .d_enable        (d_enable),
        .stb_high_enable (stb_high_enable),
        .is_nop          (is_nop),
        .ctrl            (rom_ctrl)
    );

    // output register empty or being taken this cycle
    assign out_free = !ctrl_valid || ctrl_ready;
    assign pop      = out_free && !q_empty;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ctrl_valid <= 1'b0;
        else if (out_free)
            ctrl_valid <= !q_empty;
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            ctrl <= rom_ctrl;
            ir   <= q_word;
        end
    end

endmodule : decode_stage

//--- logic/lc3b_decode_front.sv
`timescale 1ns/1ps

module lc3b_decode_front
    import lc3b_types::*;
    import apb_types::*;
#(
    parameter apb_addr RESET_PC    = 16'h0000,
    parameter int      QUEUE_DEPTH = 4   // power of two
)
(
    input  logic              clk,
    input  logic              arst_n,
    output apb_addr           paddr,
    output logic              psel,
    output logic              penable,
    input  lc3b_word          prdata,
    input  logic              pready,
    input  logic              pslverr,
    output lc3b_control_word  ctrl,
    output lc3b_word          ir,
    output logic              ctrl_valid,
    input  logic              ctrl_ready
);

    logic      full;
    logic      push_valid;
    lc3b_word  push_word;
    lc3b_word  q_word;
    logic      q_empty;
    logic      pop;

    ifetch_apb #(.RESET_PC(RESET_PC)) u_ifetch_apb
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .full       (full),
        .push_valid (push_valid),
        .push_word  (push_word)
    );

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_inst_queue
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .push_valid (push_valid),
        .push_word  (push_word),
        .full       (full),
        .pop        (pop),
        .q_word     (q_word),
        .q_empty    (q_empty)
    );

    decode_stage u_decode_stage
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .q_word     (q_word),
        .q_empty    (q_empty),
        .pop        (pop),
        .ctrl       (ctrl),
        .ir         (ir),
        .ctrl_valid (ctrl_valid),
        .ctrl_ready (ctrl_ready)
    );

endmodule : lc3b_decode_front

//--- test/tb_lc3b_decode_front.sv
`timescale 1ns/1ps

module tb_lc3b_decode_front
    import lc3b_types::*;
    import apb_types::*;
();

    localparam apb_addr    RESET_PC    = 16'h0020;
    localparam int         QUEUE_DEPTH = 4;
    localparam int         N_PAT       = 24;
    localparam int         NOP_IDX     = 0;    // entry holding the plain nop br
    localparam int         ERR_K       = 2*N_PAT + 3;
    localparam apb_addr    ERR_ADDR    = RESET_PC + apb_addr'(2*ERR_K);
    localparam int         HOLD_CYCLES = 48;
    localparam int         FULL_CHECK  = 12;   // last cycles of the hold where fetch must be idle
    localparam int         WAIT_LIMIT  = 2000;
    localparam logic [1:0] RDY_HIGH    = 2'd0;
    localparam logic [1:0] RDY_RANDOM  = 2'd1;
    localparam logic [1:0] RDY_LOW     = 2'd2;

    logic              clk;
    logic              arst_n;
    apb_addr           paddr;
    logic              psel;
    logic              penable;
    lc3b_word          prdata;
    logic              pready;
    logic              pslverr;
    lc3b_control_word  ctrl;
    lc3b_word          ir;
    logic              ctrl_valid;
    logic              ctrl_ready;

    logic [35:0]       pat_mem [0:2*N_PAT-1];   // word, expected ctrl, word, ...
    logic [31:0]       rng;
    logic [1:0]        ready_mode;
    int                wait_left;
    logic              s_psel;
    logic              s_penable;
    apb_addr           s_paddr;
    logic              held;
    lc3b_control_word  held_ctrl;
    lc3b_word          held_ir;
    int                accepted;
    int                errors;
    int                ir_errs;
    int                ctrl_errs;
    int                tests_run;
    bit                timed_out;

    lc3b_decode_front #(.RESET_PC(RESET_PC), .QUEUE_DEPTH(QUEUE_DEPTH)) UUT
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .ctrl       (ctrl),
        .ir         (ir),
        .ctrl_valid (ctrl_valid),
        .ctrl_ready (ctrl_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    // ####################
    // helpers and checks
    // ####################

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int word_index(input apb_addr addr);
        return int'(addr >> 1) % N_PAT;   // memory image repeats every N_PAT words
    endfunction

    function automatic lc3b_word pattern_word(input int idx);
        return pat_mem[2*idx][15:0];
    endfunction

    function automatic lc3b_control_word pattern_ctrl(input int idx);
        lc3b_control_word c;
        c = pat_mem[2*idx+1][34:0];
        return c;
    endfunction

    task automatic check_ctrl(input string name, input lc3b_control_word exp,
                              input lc3b_control_word act);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
            ctrl_errs++;
        end
    endtask

    task automatic check_ir(input string name, input lc3b_word exp, input lc3b_word act);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
            ir_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input apb_addr exp, input apb_addr act);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // k-th accepted instruction comes from RESET_PC + 2k
    task automatic check_accept();
        apb_addr           addr;
        lc3b_word          exp_ir;
        lc3b_control_word  exp_ctrl;
        addr = RESET_PC + apb_addr'(2*accepted);
        if (addr == ERR_ADDR)
        begin
            exp_ir   = '0;   // slave error turns into a nop br
            exp_ctrl = pattern_ctrl(NOP_IDX);
            check_flag("ctrl.is_nop", 1'b1, ctrl.is_nop);
            check_flag("ctrl.load_pc", 1'b0, ctrl.load_pc);
        end
        else
        begin
            exp_ir   = pattern_word(word_index(addr));
            exp_ctrl = pattern_ctrl(word_index(addr));
        end
        check_ir("ir", exp_ir, ir);
        check_ctrl("ctrl", exp_ctrl, ctrl);
        accepted++;
    endtask

    task automatic serve_read(input apb_addr addr);
        pready  <= 1'b1;
        prdata  <= pattern_word(word_index(addr));
        pslverr <= (addr == ERR_ADDR);
    endtask

    task automatic set_ready_mode(input logic [1:0] mode);
        @(posedge clk);
        ready_mode <= mode;
    endtask

    task automatic wait_accepts(input int target);
        int n;
        n = 0;
        while (accepted < target && n < WAIT_LIMIT)
        begin
            @(posedge clk);
            n++;
        end
        if (accepted < target)
        begin
            $display("timeout: no instruction arrived within %0d cycles, %0d of %0d accepted",
                     WAIT_LIMIT, accepted, target);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_fetch_start();
        int n;
        n = 0;
        while (!psel && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!psel)
        begin
            $display("timeout: no fetch request appeared within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    // ####################
    // apb slave and ready
    // ####################

    always @(posedge clk)
    begin
        rng = lcg_next(rng);
        case (ready_mode)
            RDY_HIGH: ctrl_ready <= 1'b1;
            RDY_LOW:  ctrl_ready <= 1'b0;
            default:  ctrl_ready <= rng[29];
        endcase

        if (s_psel && !s_penable)
        begin
            rng = lcg_next(rng);   // 0 to 3 wait states
            if (rng[31:30] == 2'd0)
                serve_read(s_paddr);
            else
                pready <= 1'b0;
            wait_left <= int'(rng[31:30]);
        end
        else if (s_psel && s_penable)
        begin
            if (pready)
            begin
                pready  <= 1'b0;   // transfer completes on this edge
                pslverr <= 1'b0;
            end
            else if (wait_left == 1)
                serve_read(s_paddr);
            else
                wait_left <= wait_left - 1;
        end
        else
        begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end
    end

    // sample mid cycle for the handshake and stall checks
    always @(negedge clk)
    begin
        s_psel    = psel;
        s_penable = penable;
        s_paddr   = paddr;
        if (held)
        begin
            check_flag("ctrl_valid (stalled)", 1'b1, ctrl_valid);
            check_ctrl("ctrl (stalled)", held_ctrl, ctrl);
            check_ir("ir (stalled)", held_ir, ir);
        end
        held      = ctrl_valid && !ctrl_ready;
        held_ctrl = ctrl;
        held_ir   = ir;
        if (ctrl_valid && ctrl_ready)
            check_accept();
    end

    // ####################
    // test sequence
    // ####################

    initial
    begin
        int start_err;
        int start_ir;
        int start_ctrl;
        arst_n     = 1'b0;
        prdata     = '0;
        pready     = 1'b0;
        pslverr    = 1'b0;
        ctrl_ready = 1'b0;
        ready_mode = RDY_LOW;
        rng        = 32'h34ea_732b;
        wait_left  = 0;
        s_psel     = 1'b0;
        s_penable  = 1'b0;
        s_paddr    = '0;
        held       = 1'b0;
        accepted   = 0;
        errors     = 0;
        ir_errs    = 0;
        ctrl_errs  = 0;
        tests_run  = 0;
        timed_out  = 1'b0;
        $readmemh("test/decode_patterns.txt", pat_mem);

        // test 1 checks reset values and first address
        start_err = errors;
        repeat (9) @(posedge clk);
        @(negedge clk);
        check_flag("psel", 1'b0, psel);
        check_flag("penable", 1'b0, penable);
        check_flag("ctrl_valid", 1'b0, ctrl_valid);
        @(posedge clk);
        arst_n <= 1'b1;   // released on the 10th edge
        wait_fetch_start();
        if (!timed_out)
        begin
            check_addr("paddr", RESET_PC, paddr);
            check_flag("penable", 1'b0, penable);   // setup phase first
            tests_run++;
            $display("test 1 reset and first fetch: %0d errors", errors - start_err);
        end

        // tests 2 and 3 share one pass over all patterns
        if (!timed_out)
        begin
            start_ir   = ir_errs;
            start_ctrl = ctrl_errs;
            set_ready_mode(RDY_RANDOM);
            wait_accepts(N_PAT);
            if (!timed_out)
            begin
                tests_run += 2;
                $display("test 2 fetch order: %0d words, %0d ir errors",
                         accepted, ir_errs - start_ir);
                $display("test 3 decode: %0d control words, %0d ctrl errors",
                         accepted, ctrl_errs - start_ctrl);
            end
        end

        // test 4 long stall fills the queue
        if (!timed_out)
        begin
            start_err = errors;
            set_ready_mode(RDY_LOW);
            for (int n = 0; n < HOLD_CYCLES; n++)
            begin
                @(negedge clk);
                if (n >= HOLD_CYCLES - FULL_CHECK)
                    check_flag("psel (queue full)", 1'b0, psel);
            end
            check_flag("ctrl_valid", 1'b1, ctrl_valid);
            set_ready_mode(RDY_RANDOM);
            wait_accepts(2*N_PAT);
            if (!timed_out)
            begin
                tests_run++;
                $display("test 4 back-pressure: held %0d cycles, %0d words in order, %0d errors",
                         HOLD_CYCLES, accepted, errors - start_err);
            end
        end

        // test 5 slave error
        if (!timed_out)
        begin
            start_err = errors;
            set_ready_mode(RDY_HIGH);
            wait_accepts(ERR_K + 4);
            if (!timed_out)
            begin
                tests_run++;
                $display("test 5 pslverr at %h: %0d errors", ERR_ADDR, errors - start_err);
            end
        end

        $display("tests run: %0d, failed checks: %0d, timeout: %0d",
                 tests_run, errors, timed_out);
        if (timed_out || errors != 0)
            $display("TEST FAILED");
        else
            $display("TEST OK");
        $finish;
    end

endmodule : tb_lc3b_decode_front

//--- sources.f
logic/lc3b_types.sv
logic/apb_types.sv
logic/control_rom.sv
logic/ifetch_apb.sv
logic/inst_queue.sv
logic/decode_stage.sv
logic/lc3b_decode_front.sv
test/tb_lc3b_decode_front.sv

//--- Bender.yml
package:
  name: lc3b_decode_front

sources:
  - logic/lc3b_types.sv
  - logic/apb_types.sv
  - logic/control_rom.sv
  - logic/ifetch_apb.sv
  - logic/inst_queue.sv
  - logic/decode_stage.sv
  - logic/lc3b_decode_front.sv
  - target: test
    files:
      - test/tb_lc3b_decode_front.sv

//--- test/decode_patterns.txt
// one pattern per line
// column 1 instruction word, column 2 expected 35-bit control word, both hex
0000 000000007  // br with no nzp, nop
0E05 040100006  // brnzp
0810 040100006  // brn
1283 092000006  // add r1, r2, r3
12A5 092020006  // add r1, r2, #5
5705 292000046  // and r3, r4, r5
54A0 292020046  // and r2, r2, #0
997F 492000086  // not r4, r5
D243 692030106  // lshf r1, r1, #3
D252 692030146  // rshfl r1, r1, #2
D271 692030186  // rshfa r1, r1, #1
64C4 31E014826  // ldr r2, r3, #4
2287 11F014A26  // ldb r1, r2, #7
8B81 41E01482E  // ldi r5, r6, #1
7283 38C090016  // str r1, r2, #3
3702 18C890212  // stb r3, r4, #2 low byte
3703 18C890214  // stb r3, r4, #3 high byte
B042 58C09080E  // sti r0, r1, #2
E60A 710008006  // lea r3, #10
C080 640400006  // jmp r2
4805 25024C406  // jsr off11
40C0 25044C006  // jsrr r3
F025 7DC64F826  // trap x25
A123 000000000  // unassigned opcode
